// ==== design/spu_pkg.sv ====
package spu_pkg;

  // Decoded instruction identity, carried with every issued word
  typedef enum logic [6:0] {
    id_illegal = 7'd0,
    id_nop,
    id_lnop,
    id_a,
    id_ai,
    id_and,
    id_shl,
    id_mpy,
    id_fa,
    id_shufb,
    id_lqd
  } instr_id_e;

  typedef enum logic [2:0] {
    unit_none = 3'd0,
    unit_fixed,
    unit_shift,
    unit_fpu,
    unit_perm,
    unit_load
  } unit_e;

  // RR form, opcode in bits 31:21
  localparam logic [10:0] opc_nop   = 11'b01000000001;
  localparam logic [10:0] opc_lnop  = 11'b00000000001;
  localparam logic [10:0] opc_a     = 11'b00011000000;
  localparam logic [10:0] opc_and   = 11'b00011000001;
  localparam logic [10:0] opc_shl   = 11'b00001011011;
  localparam logic [10:0] opc_mpy   = 11'b01111000100;
  localparam logic [10:0] opc_fa    = 11'b01011000100;
  localparam logic [10:0] opc_shufb = 11'b10110000000;
  localparam logic [10:0] opc_lqd   = 11'b00111000100;

  // RI10 form, opcode in bits 31:24
  localparam logic [7:0] opc_ai = 8'b00011100;

  localparam logic [31:0] nop_word  = {opc_nop, 21'd0};
  localparam logic [31:0] lnop_word = {opc_lnop, 21'd0};

  localparam logic [3:0] lat_nop   = 4'd0;
  localparam logic [3:0] lat_fixed = 4'd2; // a, ai, and
  localparam logic [3:0] lat_shift = 4'd4;
  localparam logic [3:0] lat_perm  = 4'd4;
  localparam logic [3:0] lat_fpu   = 4'd6;
  localparam logic [3:0] lat_load  = 4'd6;
  localparam logic [3:0] lat_mpy   = 4'd7;

  typedef struct packed {
    logic [31:0] full_instr;
    instr_id_e   instr_id;
    unit_e       unit;
    logic [3:0]  latency;
    logic        reg_wr;
    logic [6:0]  rt;
    logic [6:0]  ra;
    logic [6:0]  rb;
    logic        uses_ra;
    logic        uses_rb;
    logic [31:0] imm;
  } issue_rec_t;

  // One writer moving down the execute pipeline
  typedef struct packed {
    logic       valid;
    logic [6:0] rt;
    logic [3:0] latency;
    logic [3:0] age;
  } track_rec_t;

  typedef struct packed {
    logic       valid;
    logic [6:0] rt;
  } wb_t;

  localparam issue_rec_t nop_rec = '{
    full_instr: nop_word, instr_id: id_nop, unit: unit_none, latency: lat_nop,
    reg_wr: 1'b0, rt: 7'd0, ra: 7'd0, rb: 7'd0, uses_ra: 1'b0, uses_rb: 1'b0,
    imm: 32'd0
  };

  localparam issue_rec_t lnop_rec = '{
    full_instr: lnop_word, instr_id: id_lnop, unit: unit_none, latency: lat_nop,
    reg_wr: 1'b0, rt: 7'd0, ra: 7'd0, rb: 7'd0, uses_ra: 1'b0, uses_rb: 1'b0,
    imm: 32'd0
  };

endpackage

// ==== design/instr_decode.sv ====
`timescale 1ns/100ps

module instr_decode (
  input  logic [31:0]         instr_in1,
  input  logic [31:0]         instr_in2,
  output spu_pkg::issue_rec_t dec_even,
  output spu_pkg::issue_rec_t dec_odd
);

  spu_pkg::issue_rec_t dec1;
  spu_pkg::issue_rec_t dec2;

  function automatic spu_pkg::issue_rec_t decode_word(input logic [31:0] w);
    spu_pkg::issue_rec_t r;
    logic [10:0] op11;
    logic [7:0]  op8;
    op11 = w[31:21];
    op8 = w[31:24];
    r.full_instr = w;
    r.instr_id = spu_pkg::id_illegal;
    r.unit = spu_pkg::unit_none;
    r.latency = spu_pkg::lat_nop;
    r.rt = w[6:0];
    r.ra = w[13:7];
    r.rb = w[20:14];
    r.imm = 32'd0;
    if (op8 == spu_pkg::opc_ai) begin
      r.instr_id = spu_pkg::id_ai;
      r.unit = spu_pkg::unit_fixed;
      r.latency = spu_pkg::lat_fixed;
      r.imm = {{22{w[23]}}, w[23:14]}; // I10 sits where rb would be
    end else begin
      case (op11)
        spu_pkg::opc_nop: r.instr_id = spu_pkg::id_nop;
        spu_pkg::opc_lnop: r.instr_id = spu_pkg::id_lnop;
        spu_pkg::opc_a: begin
          r.instr_id = spu_pkg::id_a;
          r.unit = spu_pkg::unit_fixed;
          r.latency = spu_pkg::lat_fixed;
        end
        spu_pkg::opc_and: begin
          r.instr_id = spu_pkg::id_and;
          r.unit = spu_pkg::unit_fixed;
          r.latency = spu_pkg::lat_fixed;
        end
        spu_pkg::opc_shl: begin
          r.instr_id = spu_pkg::id_shl;
          r.unit = spu_pkg::unit_shift;
          r.latency = spu_pkg::lat_shift;
        end
        spu_pkg::opc_mpy: begin
          r.instr_id = spu_pkg::id_mpy;
          r.unit = spu_pkg::unit_fpu;
          r.latency = spu_pkg::lat_mpy;
        end
        spu_pkg::opc_fa: begin
          r.instr_id = spu_pkg::id_fa;
          r.unit = spu_pkg::unit_fpu;
          r.latency = spu_pkg::lat_fpu;
        end
        spu_pkg::opc_shufb: begin
          r.instr_id = spu_pkg::id_shufb;
          r.unit = spu_pkg::unit_perm;
          r.latency = spu_pkg::lat_perm;
        end
        spu_pkg::opc_lqd: begin
          r.instr_id = spu_pkg::id_lqd;
          r.unit = spu_pkg::unit_load;
          r.latency = spu_pkg::lat_load;
        end
        default: r.instr_id = spu_pkg::id_illegal;
      endcase
    end
    // Only nop, lnop and illegal words have zero latency, and none of them writes
    r.reg_wr = (r.latency != spu_pkg::lat_nop);
    r.uses_ra = r.reg_wr;
    r.uses_rb = r.reg_wr && (r.instr_id != spu_pkg::id_ai);
    return r;
  endfunction

  function automatic logic is_odd_pipe(input spu_pkg::instr_id_e id);
    return (id == spu_pkg::id_lnop) || (id == spu_pkg::id_shufb) ||
           (id == spu_pkg::id_lqd);
  endfunction

  assign dec1 = decode_word(instr_in1);
  assign dec2 = decode_word(instr_in2);

  always_comb begin
    if (is_odd_pipe(dec1.instr_id)) begin // Pair arrived in odd, even order
      dec_even = dec2;
      dec_odd = dec1;
    end else begin
      dec_even = dec1;
      dec_odd = dec2;
    end
  end

endmodule

// ==== design/issue_stage.sv ====
`timescale 1ns/100ps

module issue_stage #(
  parameter int NUM_REGS = 128
) (
  input  logic                clk,
  input  logic                rst,
  input  spu_pkg::issue_rec_t dec_even,
  input  spu_pkg::issue_rec_t dec_odd,
  input  logic                pair_valid,
  input  logic                branch_taken,
  input  logic [NUM_REGS-1:0] busy,
  input  logic [9:0]          pc_in,
  output logic                stall,
  output logic                flush,
  output logic [9:0]          pc_out,
  output spu_pkg::issue_rec_t issue_even,
  output spu_pkg::issue_rec_t issue_odd
);

  logic [NUM_REGS-1:0] pend_mask;
  logic [NUM_REGS-1:0] eff_busy;
  logic                hazard_even;
  logic                hazard_odd;
  logic                load_nops;

  // The busy table only sees a writer once it sits in the issue registers,
  // so the writers issued at the last edge are added here
  always_comb begin
    pend_mask = '0;
    if (issue_even.reg_wr) begin
      pend_mask[issue_even.rt] = 1'b1;
    end
    if (issue_odd.reg_wr) begin
      pend_mask[issue_odd.rt] = 1'b1;
    end
  end

  assign eff_busy = busy | pend_mask;

  function automatic logic has_hazard(input spu_pkg::issue_rec_t r,
                                      input logic [NUM_REGS-1:0] b);
    logic raw;
    logic waw;
    raw = (r.uses_ra && b[r.ra]) || (r.uses_rb && b[r.rb]);
    waw = r.reg_wr && b[r.rt];
    return raw || waw;
  endfunction

  assign hazard_even = has_hazard(dec_even, eff_busy);
  assign hazard_odd = has_hazard(dec_odd, eff_busy);
  assign stall = pair_valid && (hazard_even || hazard_odd);

  assign load_nops = stall || branch_taken || !pair_valid;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      issue_even <= spu_pkg::nop_rec;
      issue_odd <= spu_pkg::lnop_rec;
      flush <= 1'b0;
      pc_out <= 10'd0;
    end else begin
      flush <= branch_taken; // One cycle pulse alongside the nop pair
      pc_out <= pc_in;
      if (load_nops) begin
        issue_even <= spu_pkg::nop_rec;
        issue_odd <= spu_pkg::lnop_rec;
      end else begin
        issue_even <= dec_even;
        issue_odd <= dec_odd;
      end
    end
  end

endmodule

// ==== design/pipe_tracker.sv ====
`timescale 1ns/100ps

module pipe_tracker #(
  parameter int MAX_LATENCY = 7
) (
  input  logic                clk,
  input  logic                rst,
  input  spu_pkg::issue_rec_t issue_even,
  input  spu_pkg::issue_rec_t issue_odd,
  output spu_pkg::wb_t        wb_even,
  output spu_pkg::wb_t        wb_odd
);

  // Pipe 0 is even, pipe 1 is odd
  for (genvar p = 0; p < 2; p++) begin : g_pipe
    spu_pkg::issue_rec_t rec_in;
    spu_pkg::track_rec_t stage [1:MAX_LATENCY];
    spu_pkg::wb_t        wb_out;

    assign rec_in = (p == 0) ? issue_even : issue_odd;

    always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
        for (int k = 1; k <= MAX_LATENCY; k++) begin
          stage[k] <= '0;
        end
      end else begin
        stage[1].valid <= rec_in.reg_wr;
        stage[1].rt <= rec_in.rt;
        stage[1].latency <= rec_in.latency;
        stage[1].age <= 4'd1;
        for (int k = 2; k <= MAX_LATENCY; k++) begin
          stage[k].rt <= stage[k-1].rt;
          stage[k].latency <= stage[k-1].latency;
          stage[k].age <= stage[k-1].age + 4'd1;
          // A record retires once it has written back
          stage[k].valid <= stage[k-1].valid && (stage[k-1].age != stage[k-1].latency);
        end
      end
    end

    always_comb begin
      wb_out = '0;
      for (int k = 1; k <= MAX_LATENCY; k++) begin
        if (stage[k].valid && (stage[k].age == stage[k].latency)) begin
          wb_out.valid = 1'b1;
          wb_out.rt = stage[k].rt;
        end
      end
    end
  end

  assign wb_even = g_pipe[0].wb_out;
  assign wb_odd = g_pipe[1].wb_out;

endmodule

// ==== design/reg_busy_table.sv ====
`timescale 1ns/100ps

module reg_busy_table #(
  parameter int NUM_REGS = 128
) (
  input  logic                clk,
  input  logic                rst,
  input  spu_pkg::issue_rec_t issue_even,
  input  spu_pkg::issue_rec_t issue_odd,
  input  spu_pkg::wb_t        wb_even,
  input  spu_pkg::wb_t        wb_odd,
  output logic [NUM_REGS-1:0] busy
);

  logic [NUM_REGS-1:0] set_mask;
  logic [NUM_REGS-1:0] clr_mask;

  always_comb begin
    set_mask = '0;
    clr_mask = '0;
    if (issue_even.reg_wr) begin
      set_mask[issue_even.rt] = 1'b1;
    end
    if (issue_odd.reg_wr) begin
      set_mask[issue_odd.rt] = 1'b1;
    end
    if (wb_even.valid) begin
      clr_mask[wb_even.rt] = 1'b1;
    end
    if (wb_odd.valid) begin
      clr_mask[wb_odd.rt] = 1'b1;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      busy <= '0;
    end else begin
      busy <= (busy & ~clr_mask) | set_mask; // New writer beats a retiring one
    end
  end

endmodule

// ==== design/spu_issue_top.sv ====
`timescale 1ns/100ps

module spu_issue_top #(
  parameter int NUM_REGS    = 128,
  parameter int MAX_LATENCY = 7
) (
  input  logic                clk,
  input  logic                rst,
  input  logic [31:0]         instr_in1,
  input  logic [31:0]         instr_in2,
  input  logic                pair_valid,
  input  logic                branch_taken,
  input  logic [9:0]          pc_in,
  output spu_pkg::issue_rec_t issue_even,
  output spu_pkg::issue_rec_t issue_odd,
  output logic                stall,
  output logic                flush,
  output logic [9:0]          pc_out,
  output spu_pkg::wb_t        wb_even,
  output spu_pkg::wb_t        wb_odd
);

  spu_pkg::issue_rec_t dec_even;
  spu_pkg::issue_rec_t dec_odd;
  logic [NUM_REGS-1:0] busy;

  instr_decode instr_decode_i (
    .instr_in1 (instr_in1),
    .instr_in2 (instr_in2),
    .dec_even  (dec_even),
    .dec_odd   (dec_odd)
  );

  issue_stage #(
    .NUM_REGS (NUM_REGS)
  ) issue_stage_i (
    .clk          (clk),
    .rst          (rst),
    .dec_even     (dec_even),
    .dec_odd      (dec_odd),
    .pair_valid   (pair_valid),
    .branch_taken (branch_taken),
    .busy         (busy),
    .pc_in        (pc_in),
    .stall        (stall),
    .flush        (flush),
    .pc_out       (pc_out),
    .issue_even   (issue_even),
    .issue_odd    (issue_odd)
  );

  pipe_tracker #(
    .MAX_LATENCY (MAX_LATENCY)
  ) pipe_tracker_i (
    .clk        (clk),
    .rst        (rst),
    .issue_even (issue_even),
    .issue_odd  (issue_odd),
    .wb_even    (wb_even),
    .wb_odd     (wb_odd)
  );

  reg_busy_table #(
    .NUM_REGS (NUM_REGS)
  ) reg_busy_table_i (
    .clk        (clk),
    .rst        (rst),
    .issue_even (issue_even),
    .issue_odd  (issue_odd),
    .wb_even    (wb_even),
    .wb_odd     (wb_odd),
    .busy       (busy)
  );

endmodule

// ==== tests/spu_checker.sv ====
`timescale 1ns/100ps

module spu_checker (
  input logic                clk,
  input logic                rst,
  input logic [31:0]         instr_in1,
  input logic [31:0]         instr_in2,
  input logic                pair_valid,
  input logic                stall,
  input logic                flush,
  input logic [9:0]          pc_out,
  input spu_pkg::issue_rec_t issue_even,
  input spu_pkg::issue_rec_t issue_odd,
  input spu_pkg::wb_t        wb_even,
  input spu_pkg::wb_t        wb_odd
);

  int cyc = 0;
  int err_count = 0;
  int tests_done = 0;
  int tests_ok = 0;
  int busy_until [128];
  logic due_v [2][16];
  logic [6:0] due_rt [2][16];
  logic exp_stall;
  logic nop_due = 1'b0;
  logic cur_v = 1'b0;
  logic chk_v = 1'b0;
  string cur_name, chk_name;
  spu_pkg::issue_rec_t cur_even, cur_odd, chk_even, chk_odd;
  logic cur_br, chk_br;
  logic [9:0] cur_pc, chk_pc;

  initial begin
    for (int r = 0; r < 128; r++) begin
      busy_until[r] = -1;
    end
    for (int s = 0; s < 16; s++) begin
      due_v[0][s] = 1'b0;
      due_v[1][s] = 1'b0;
    end
  end

  // Busy from the issue cycle through the wb cycle
  function automatic logic reg_busy(input logic [6:0] r);
    return busy_until[r] >= cyc;
  endfunction

  function automatic logic word_hazard(input logic [31:0] w);
    logic wr;
    logic use_rb;
    wr = (w != spu_pkg::nop_word) && (w != spu_pkg::lnop_word);
    use_rb = wr && (w[31:24] != spu_pkg::opc_ai); // ai has I10 where rb would be
    return wr && (reg_busy(w[6:0]) || reg_busy(w[13:7]) || (use_rb && reg_busy(w[20:14])));
  endfunction

  task automatic cmp(input string name, input string field, input logic [31:0] exp_v,
                     input logic [31:0] act_v, inout int bad);
    if (exp_v !== act_v) begin
      $display("FAILED %s %s expected %0h actual %0h", name, field, exp_v, act_v);
      bad++;
    end
  endtask

  task automatic cmp_rec(input string name, input string pipe, input spu_pkg::issue_rec_t e,
                         input spu_pkg::issue_rec_t a, inout int bad);
    cmp(name, {pipe, ".instr_id"}, e.instr_id, a.instr_id, bad);
    cmp(name, {pipe, ".rt"}, e.rt, a.rt, bad);
    cmp(name, {pipe, ".latency"}, e.latency, a.latency, bad);
    cmp(name, {pipe, ".imm"}, e.imm, a.imm, bad);
    cmp(name, {pipe, ".reg_wr"}, e.reg_wr, a.reg_wr, bad);
  endtask

  task automatic present(input string name, input spu_pkg::issue_rec_t e_even,
                         input spu_pkg::issue_rec_t e_odd, input logic br, input logic [9:0] pc);
    cur_name = name;
    cur_even = e_even;
    cur_odd = e_odd;
    cur_br = br;
    cur_pc = pc;
    cur_v = 1'b1;
  endtask

  task automatic check_reset();
    int bad;
    bad = 0;
    cmp("reset", "issue_even.instr_id", spu_pkg::id_nop, issue_even.instr_id, bad);
    cmp("reset", "issue_odd.instr_id", spu_pkg::id_lnop, issue_odd.instr_id, bad);
    cmp("reset", "reg_wr", 2'b00, {issue_even.reg_wr, issue_odd.reg_wr}, bad);
    cmp("reset", "stall,flush", 2'b00, {stall, flush}, bad);
    cmp("reset", "wb valid", 2'b00, {wb_even.valid, wb_odd.valid}, bad);
    if (bad == 0) begin
      $display("ok reset");
      tests_ok++;
    end
    tests_done++;
    err_count += bad;
  endtask

  task automatic note_issue(input int p, input spu_pkg::issue_rec_t r);
    if (r.reg_wr) begin
      busy_until[r.rt] = cyc + r.latency;
      due_v[p][(cyc + r.latency) % 16] = 1'b1;
      due_rt[p][(cyc + r.latency) % 16] = r.rt;
    end
  endtask

  task automatic check_wb(input int p, input spu_pkg::wb_t w);
    int s;
    s = cyc % 16;
    if (w.valid !== due_v[p][s] || (w.valid && w.rt !== due_rt[p][s])) begin
      $display("wb on pipe %0d in cycle %0d is wrong: valid %b rt %0d, expected valid %b rt %0d",
               p, cyc, w.valid, w.rt, due_v[p][s], due_rt[p][s]);
      err_count++;
    end
    due_v[p][s] = 1'b0;
  endtask

  always @(negedge clk) begin
    int bad;
    if (!rst) begin
      note_issue(0, issue_even);
      note_issue(1, issue_odd);
      check_wb(0, wb_even);
      check_wb(1, wb_odd);
      exp_stall = pair_valid && (word_hazard(instr_in1) || word_hazard(instr_in2));
      if (stall !== exp_stall) begin
        $display("stall is %b in cycle %0d but the busy model expects %b", stall, cyc, exp_stall);
        err_count++;
      end
      if (nop_due && (issue_even.instr_id !== spu_pkg::id_nop || issue_even.reg_wr !== 1'b0 ||
                      issue_odd.instr_id !== spu_pkg::id_lnop || issue_odd.reg_wr !== 1'b0)) begin
        $display("a stalled cycle in cycle %0d was not followed by a nop pair", cyc);
        err_count++;
      end
      nop_due = 1'b0;
      if (chk_v) begin
        bad = 0;
        cmp_rec(chk_name, "even", chk_even, issue_even, bad);
        cmp_rec(chk_name, "odd", chk_odd, issue_odd, bad);
        cmp(chk_name, "flush", chk_br, flush, bad);
        cmp(chk_name, "pc_out", chk_pc, pc_out, bad);
        if (bad == 0) begin
          $display("ok %s", chk_name);
          tests_ok++;
        end
        tests_done++;
        err_count += bad;
        chk_v = 1'b0;
      end
      if (exp_stall) begin
        nop_due = 1'b1;
      end else if (cur_v) begin // The presented pair leaves at the next edge
        chk_name = cur_name;
        chk_even = cur_even;
        chk_odd = cur_odd;
        chk_br = cur_br;
        chk_pc = cur_pc;
        chk_v = 1'b1;
        cur_v = 1'b0;
      end
      cyc++;
    end
  end

endmodule

// ==== tests/spu_issue_assert.sv ====
`timescale 1ns/100ps

module spu_issue_assert (
  input logic                clk,
  input logic                rst,
  input logic                pair_valid,
  input logic                branch_taken,
  input logic                stall,
  input logic                flush,
  input logic [9:0]          pc_out,
  input spu_pkg::issue_rec_t issue_even,
  input spu_pkg::issue_rec_t issue_odd
);

  logic nop_pair;

  assign nop_pair = (issue_even.instr_id == spu_pkg::id_nop) && !issue_even.reg_wr &&
                    (issue_odd.instr_id == spu_pkg::id_lnop) && !issue_odd.reg_wr;

  stall_needs_valid: assert property (@(posedge clk) disable iff (rst) stall |-> pair_valid)
    else $error("stall high while pair_valid is low");

  nop_after_hold: assert property (@(posedge clk) disable iff (rst)
    (stall || branch_taken) |=> nop_pair)
    else $error("pair issued after a stall or branch is not the nop pair");

  known_outputs: assert property (@(posedge clk) disable iff (rst)
    !$isunknown({stall, flush, pc_out, issue_even, issue_odd}))
    else $error("issue stage output is unknown");

endmodule

bind issue_stage spu_issue_assert spu_issue_assert_i (.*);

// ==== tests/tb_spu_issue.sv ====
`timescale 1ns/100ps

module tb_spu_issue;

  localparam int MAX_LATENCY = 7;
  localparam int MAX_ENTRIES = 16;

  logic clk, rst, pair_valid, branch_taken, stall, flush;
  logic [31:0] instr_in1, instr_in2;
  logic [9:0] pc_in, pc_out;
  spu_pkg::issue_rec_t issue_even, issue_odd;
  spu_pkg::wb_t wb_even, wb_odd;

  string t_name [MAX_ENTRIES];
  logic [31:0] t_w1 [MAX_ENTRIES];
  logic [31:0] t_w2 [MAX_ENTRIES];
  logic t_pv [MAX_ENTRIES];
  logic t_br [MAX_ENTRIES];
  spu_pkg::issue_rec_t t_even [MAX_ENTRIES];
  spu_pkg::issue_rec_t t_odd [MAX_ENTRIES];
  int n_entries = 0;
  int cycles = 0;

  spu_issue_top #(.NUM_REGS(128), .MAX_LATENCY(MAX_LATENCY)) spu_issue_top_i (.*);

  spu_checker checker_i (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] rr(input logic [10:0] opc, input logic [6:0] rb,
                                     input logic [6:0] ra, input logic [6:0] rt);
    return {opc, rb, ra, rt};
  endfunction

  function automatic logic [31:0] ri(input logic [7:0] opc, input logic [9:0] i10,
                                     input logic [6:0] ra, input logic [6:0] rt);
    return {opc, i10, ra, rt};
  endfunction

  function automatic spu_pkg::issue_rec_t exp_rec(input spu_pkg::instr_id_e id,
      input logic [6:0] rt, input logic [3:0] lat, input logic [31:0] imm);
    spu_pkg::issue_rec_t r;
    r = '0;
    r.instr_id = id;
    r.rt = rt;
    r.latency = lat;
    r.imm = imm;
    // Every instruction of the subset writes rt except the no-ops
    r.reg_wr = (id != spu_pkg::id_nop) && (id != spu_pkg::id_lnop) &&
               (id != spu_pkg::id_illegal);
    return r;
  endfunction

  task automatic add_entry(input string name, input logic [31:0] w1, input logic [31:0] w2,
                           input logic pv, input logic br, input spu_pkg::issue_rec_t e_even,
                           input spu_pkg::issue_rec_t e_odd);
    t_name[n_entries] = name;
    t_w1[n_entries] = w1;
    t_w2[n_entries] = w2;
    t_pv[n_entries] = pv;
    t_br[n_entries] = br;
    t_even[n_entries] = e_even;
    t_odd[n_entries] = e_odd;
    n_entries++;
  endtask

  task automatic load_table();
    spu_pkg::issue_rec_t nop_e, lnop_e;
    nop_e = exp_rec(spu_pkg::id_nop, 0, 0, 0);
    lnop_e = exp_rec(spu_pkg::id_lnop, 0, 0, 0);
    add_entry("dec_a_shufb", rr(spu_pkg::opc_a, 2, 1, 10), rr(spu_pkg::opc_shufb, 4, 3, 11),
              1, 0, exp_rec(spu_pkg::id_a, 10, 2, 0), exp_rec(spu_pkg::id_shufb, 11, 4, 0));
    add_entry("dec_swap_lqd_ai", rr(spu_pkg::opc_lqd, 6, 5, 12),
              ri(spu_pkg::opc_ai, 10'h3fb, 7, 13), 1, 0,
              exp_rec(spu_pkg::id_ai, 13, 2, 32'hffff_fffb), exp_rec(spu_pkg::id_lqd, 12, 6, 0));
    add_entry("raw_on_r12", rr(spu_pkg::opc_and, 12, 8, 14), spu_pkg::lnop_word, 1, 0,
              exp_rec(spu_pkg::id_and, 14, 2, 0), lnop_e);
    add_entry("waw_on_r14", rr(spu_pkg::opc_shl, 9, 8, 14), spu_pkg::lnop_word, 1, 0,
              exp_rec(spu_pkg::id_shl, 14, 4, 0), lnop_e);
    add_entry("idle_gap", 32'd0, 32'd0, 0, 0, nop_e, lnop_e);
    add_entry("mpy_long", rr(spu_pkg::opc_mpy, 1, 2, 20), spu_pkg::lnop_word, 1, 0,
              exp_rec(spu_pkg::id_mpy, 20, 7, 0), lnop_e);
    add_entry("a_overlaps_mpy", rr(spu_pkg::opc_a, 3, 4, 21), rr(spu_pkg::opc_shufb, 1, 2, 22),
              1, 0, exp_rec(spu_pkg::id_a, 21, 2, 0), exp_rec(spu_pkg::id_shufb, 22, 4, 0));
    add_entry("branch_drop", rr(spu_pkg::opc_fa, 1, 2, 30), rr(spu_pkg::opc_lqd, 1, 2, 31),
              1, 1, nop_e, lnop_e);
    add_entry("read_after_flush", rr(spu_pkg::opc_a, 31, 30, 32), spu_pkg::lnop_word, 1, 0,
              exp_rec(spu_pkg::id_a, 32, 2, 0), lnop_e);
    add_entry("idle_end", 32'd0, 32'd0, 0, 0, nop_e, lnop_e);
  endtask

  initial begin
    rst = 1'b1;
    instr_in1 = 32'd0;
    instr_in2 = 32'd0;
    pair_valid = 1'b0;
    branch_taken = 1'b0;
    pc_in = 10'd0;
    load_table();
    repeat (8) @(posedge clk);
    #5;
    checker_i.check_reset();
    rst = 1'b0;
    for (int i = 0; i < n_entries; i++) begin
      @(posedge clk);
      #5;
      instr_in1 = t_w1[i];
      instr_in2 = t_w2[i];
      pair_valid = t_pv[i];
      branch_taken = t_br[i];
      pc_in = 10'(i + 1);
      checker_i.present(t_name[i], t_even[i], t_odd[i], t_br[i], 10'(i + 1));
      @(negedge clk);
      while (stall) @(negedge clk); // Hold the pair until it can issue
    end
    @(posedge clk);
    #5;
    pair_valid = 1'b0;
    branch_taken = 1'b0;
    repeat (MAX_LATENCY + 2) @(posedge clk);
    $display("%0d tests, %0d passed, %0d errors", checker_i.tests_done, checker_i.tests_ok,
             checker_i.err_count);
    if (checker_i.err_count == 0 && checker_i.tests_done == n_entries + 1) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin
    #1;
    while (cycles <= n_entries * (MAX_LATENCY + 2) + 50) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, the stimulus did not complete", cycles);
    $display("tests failed");
    $finish;
  end

endmodule

// ==== filelist.f ====
design/spu_pkg.sv
design/instr_decode.sv
design/issue_stage.sv
design/pipe_tracker.sv
design/reg_busy_table.sv
design/spu_issue_top.sv
tests/spu_checker.sv
tests/spu_issue_assert.sv
tests/tb_spu_issue.sv
